// ==== include/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// data and address width
`define XLEN 32

// first fetch address after reset, also the SEL_RESET target
`define RESET_VECTOR 32'h0000_0000

// instruction memory depth, 256 words
`define IMEM_WORDS_LOG2 8

`define MTVEC_RESET 32'h0000_0100 // trap vector until software writes mtvec

`endif

// ==== src/archPkg.sv ====
`default_nettype none

`include "fetch_settings.svh"

package archPkg;

	// one instruction or one byte address
	typedef logic [`XLEN-1:0] word_t;

	// next fetch address choice
	typedef enum logic [1:0]
	{
		SEL_SEQ    = 2'b00, // pc + 4
		SEL_RESET  = 2'b01, // back to reset vector
		SEL_TARGET = 2'b10, // branch / jump target
		SEL_MRET   = 2'b11  // return to saved mepc
	} pcSel_t;

	// trap unit state
	// pending set by an irq edge, cleared when the redirect is taken
	// inService masks new requests until mret
	typedef struct packed
	{
		logic pending;
		logic inService;
	} trapState_t;

endpackage

`default_nettype wire

// ==== src/memPkg.sv ====
`default_nettype none

`include "fetch_settings.svh"

package memPkg;

	// word index, byte address bits [IMEM_WORDS_LOG2+1:2]
	typedef logic [`IMEM_WORDS_LOG2-1:0] wordIdx_t;

	// one debug write into instruction memory
	typedef struct packed
	{
		logic           we;    // write strobe
		wordIdx_t       index; // target word
		archPkg::word_t data;  // word to store
	} dbgWrite_t;

endpackage

`default_nettype wire

// ==== src/fetchIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// one fetch slot between stage 1 and stage 2
interface fetchIf
	import archPkg::*;
();

	word_t pc;         // aligned fetch address
	logic  valid;      // slot holds a real address
	logic  misaligned; // source address had low bits set
	logic  stall;      // freeze, from top level
	logic  advance;    // edge accepted, both stages move

	// stage 1 side
	modport producer (output pc, valid, misaligned, advance, input stall);

	// stage 2 side
	modport consumer (input pc, valid, misaligned, advance);

endinterface

`default_nettype wire

// ==== src/pcGen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module pcGen
	import archPkg::*;
(
	input  logic    clk,
	input  logic    nrst,
	input  pcSel_t  pcSel,     // next address select
	input  word_t   target,    // branch target, may be misaligned
	input  logic    redirect,  // trap taken, wins over pcSel
	input  word_t   mtvec,
	input  word_t   mepc,
	output word_t   seqNext,   // pc + 4, saved as mepc on a trap
	output logic    mretTaken,
	fetchIf.producer slot
);

	word_t pcReg;     // stage 1 fetch address
	logic  misReg;    // misaligned flag for pcReg
	logic  validReg;  // low until first accepted edge
	word_t nextPc;
	logic  nextMis;

	// stall is the only back-pressure
	assign slot.advance = !slot.stall;

	assign seqNext = pcReg + word_t'(4);

	// mret only counts when the trap redirect does not override it
	assign mretTaken = slot.advance && !redirect && (pcSel == SEL_MRET);

	// next address, trap first then pcSel
	always_comb
	begin
		nextPc  = seqNext;
		nextMis = 1'b0;
		if (redirect)
		begin
			nextPc = mtvec; // trap entry
		end
		else
		begin
			case (pcSel)
				SEL_SEQ:    nextPc = seqNext;
				SEL_RESET:  nextPc = `RESET_VECTOR;
				SEL_TARGET:
				begin
					nextPc  = {target[`XLEN-1:2], 2'b00}; // align down
					nextMis = |target[1:0];               // flag the bad target
				end
				SEL_MRET:   nextPc = mepc;
				default:    nextPc = seqNext;
			endcase
		end
	end

	// fetch address register, holds under stall
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pcReg    <= `RESET_VECTOR;
			misReg   <= 1'b0;
			validReg <= 1'b0;
		end
		else if (slot.advance)
		begin
			pcReg    <= nextPc;
			misReg   <= nextMis;
			validReg <= 1'b1; // stays high until next reset
		end
	end

	assign slot.pc         = pcReg;
	assign slot.misaligned = misReg;
	assign slot.valid      = validReg;

endmodule

`default_nettype wire

// ==== src/trapUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module trapUnit
	import archPkg::*;
(
	input  logic  clk,
	input  logic  nrst,
	input  logic  irq,       // level request, edge detected here
	input  logic  mtvecWe,
	input  word_t mtvecData,
	input  logic  advance,   // accepted edge from stage 1
	input  word_t seqNext,   // return address candidate
	input  logic  mretTaken,
	output logic  redirect,  // send fetch to mtvec
	output word_t mtvec,
	output word_t mepc,
	output logic  inService
);

	logic       irqPrev; // last sampled irq
	logic       irqEdge;
	trapState_t state;
	logic       takeTrap; // redirect accepted this edge

	assign irqEdge   = irq && !irqPrev;
	assign redirect  = state.pending && !state.inService;
	assign takeTrap  = advance && redirect;
	assign inService = state.inService;

	// irq edge detect and trap state
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			irqPrev <= 1'b0;
			state   <= '0;
		end
		else
		begin
			irqPrev <= irq; // sampled even under stall
			if (takeTrap)
			begin
				state.pending   <= 1'b0;
				state.inService <= 1'b1;
			end
			else
			begin
				if (irqEdge && !state.inService)
					state.pending <= 1'b1; // latched under stall too
				if (mretTaken)
					state.inService <= 1'b0; // back to normal fetch
			end
		end
	end

	// return address, only meaningful after a trap
	always_ff @(posedge clk)
	begin
		if (takeTrap)
			mepc <= seqNext;
	end

	// writable trap vector, any edge
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			mtvec <= `MTVEC_RESET;
		else if (mtvecWe)
			mtvec <= mtvecData;
	end

endmodule

`default_nettype wire

// ==== src/instrMem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module instrMem
	import archPkg::*;
	import memPkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  dbgWrite_t dbg,   // program load port
	fetchIf.consumer  slot,
	output word_t     instr2,
	output word_t     pc2,
	output logic      valid2,
	output logic      misaligned2
);

	word_t    mem [2**`IMEM_WORDS_LOG2]; // no reset, loaded over debug port
	wordIdx_t rdIdx;
	logic     capture; // accepted edge with a real slot

	assign rdIdx   = slot.pc[`IMEM_WORDS_LOG2+1:2];
	assign capture = slot.advance && slot.valid;

	// debug writes ignore stall
	always_ff @(posedge clk)
	begin
		if (dbg.we)
			mem[dbg.index] <= dbg.data;
	end

	// payload, sync read gives old word on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			instr2 <= mem[rdIdx];
			pc2    <= slot.pc;
		end
	end

	// stage 2 control bits
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			valid2      <= 1'b0;
			misaligned2 <= 1'b0;
		end
		else if (capture)
		begin
			valid2      <= 1'b1;
			misaligned2 <= slot.misaligned; // travels with its pc
		end
	end

endmodule

`default_nettype wire

// ==== src/fetchTop.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module fetchTop
	import archPkg::*;
	import memPkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,      // freezes both stages
	input  logic [1:0]  pcSel,
	input  logic [31:0] target,
	input  logic        irq,
	input  logic        mtvecWe,
	input  logic [31:0] mtvecData,
	input  logic        dbgWe,      // debug program load
	input  logic [31:0] dbgAddr,    // byte address
	input  logic [31:0] dbgData,
	output logic [31:0] pc2,
	output logic [31:0] instr2,
	output logic        valid2,
	output logic        misaligned2,
	output logic        inService
);

	fetchIf    slot ();
	dbgWrite_t dbg;
	word_t     seqNext;  // stage 1 to trap unit
	word_t     mtvec;
	word_t     mepc;
	logic      redirect;
	logic      mretTaken;

	assign slot.stall = stall;

	// debug record, byte address to word index
	assign dbg.we    = dbgWe;
	assign dbg.index = dbgAddr[`IMEM_WORDS_LOG2+1:2];
	assign dbg.data  = dbgData;

	pcGen i_pcGen (
		.clk       (clk),
		.nrst      (nrst),
		.pcSel     (pcSel_t'(pcSel)),
		.target    (target),
		.redirect  (redirect),
		.mtvec     (mtvec),
		.mepc      (mepc),
		.seqNext   (seqNext),
		.mretTaken (mretTaken),
		.slot      (slot.producer)
	);

	trapUnit i_trapUnit (
		.clk       (clk),
		.nrst      (nrst),
		.irq       (irq),
		.mtvecWe   (mtvecWe),
		.mtvecData (mtvecData),
		.advance   (slot.advance),
		.seqNext   (seqNext),
		.mretTaken (mretTaken),
		.redirect  (redirect),
		.mtvec     (mtvec),
		.mepc      (mepc),
		.inService (inService)
	);

	instrMem i_instrMem (
		.clk         (clk),
		.nrst        (nrst),
		.dbg         (dbg),
		.slot        (slot.consumer),
		.instr2      (instr2),
		.pc2         (pc2),
		.valid2      (valid2),
		.misaligned2 (misaligned2)
	);

endmodule

`default_nettype wire

// ==== verification/fetchTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module fetchTb
	import archPkg::*;
	import memPkg::*;
();

	// one expected stage 2 slot
	typedef struct packed
	{
		word_t pc;
		word_t instr;
		logic  mis;
	} expSlot_t;

	logic        clk = 1'b0;
	logic        nrst, stall, irq, mtvecWe, dbgWe;
	logic [1:0]  pcSel;
	logic [31:0] target, mtvecData, dbgAddr, dbgData;
	logic [31:0] pc2, instr2;
	logic        valid2, misaligned2, inService;

	word_t    memModel [2**`IMEM_WORDS_LOG2]; // mirror of the program
	word_t    mPc, mMepc, mMtvec;
	logic     mMis, mValid, mPending, mInService, mIrqPrev;
	expSlot_t expQ [$];
	expSlot_t cur;   // what stage 2 should hold now
	logic     expV2;

	// one-shot requests driven at the next falling edge
	logic  irqReq, dbgReq, mtvecReq, nrstNext;
	word_t dbgReqAddr, dbgReqData, mtvecReqData;

	logic sampledValid2 = 1'b0; // seen at last falling edge
	logic sampledInSvc = 1'b0;
	int   errors = 0;
	int   checks = 0;
	int   tests = 0;
	int   testStart = 0;

	always #20 clk = ~clk; // 40 ns period

	fetchTop i_fetchTop (
		.clk         (clk),
		.nrst        (nrst),
		.stall       (stall),
		.pcSel       (pcSel),
		.target      (target),
		.irq         (irq),
		.mtvecWe     (mtvecWe),
		.mtvecData   (mtvecData),
		.dbgWe       (dbgWe),
		.dbgAddr     (dbgAddr),
		.dbgData     (dbgData),
		.pc2         (pc2),
		.instr2      (instr2),
		.valid2      (valid2),
		.misaligned2 (misaligned2),
		.inService   (inService)
	);

	task automatic resetModel;
		mPc        = `RESET_VECTOR;
		mMis       = 1'b0;
		mValid     = 1'b0;
		mPending   = 1'b0;
		mInService = 1'b0;
		mIrqPrev   = 1'b0;
		mMtvec     = `MTVEC_RESET;
		expV2      = 1'b0;
		expQ.delete();
	endtask

	// reference model of one rising edge with inputs as driven at the falling edge
	task automatic modelEdge;
		word_t    seqNext;
		logic     redirect;
		logic     adv;
		logic     irqEdge;
		wordIdx_t rdIdx;
		wordIdx_t wrIdx;
		expSlot_t e;
		seqNext  = mPc + 32'd4;
		redirect = mPending && !mInService; // trap wins over pcSel
		adv      = !stall;
		irqEdge  = irq && !mIrqPrev;
		rdIdx    = mPc[`IMEM_WORDS_LOG2+1:2];
		wrIdx    = dbgAddr[`IMEM_WORDS_LOG2+1:2];
		if (!nrst)
			resetModel();
		else
		begin
			if (adv && mValid)
			begin
				e.pc    = mPc;
				e.instr = memModel[rdIdx]; // old word on same-edge write
				e.mis   = mMis;
				expQ.push_back(e);
				cur   = expQ.pop_front();
				expV2 = 1'b1;
			end
			if (adv)
			begin
				mMis = 1'b0;
				if (redirect)
					mPc = mMtvec;
				else if (pcSel_t'(pcSel) == SEL_RESET)
					mPc = `RESET_VECTOR;
				else if (pcSel_t'(pcSel) == SEL_TARGET)
				begin
					mPc  = {target[31:2], 2'b00};
					mMis = |target[1:0]; // only a bad target sets it
				end
				else if (pcSel_t'(pcSel) == SEL_MRET)
					mPc = mMepc;
				else
					mPc = seqNext;
				mValid = 1'b1;
			end
			if (adv && redirect)
			begin
				mPending   = 1'b0;
				mInService = 1'b1;
				mMepc      = seqNext; // return lands after the interrupted slot
			end
			else
			begin
				if (irqEdge && !mInService)
					mPending = 1'b1; // latched under stall as well
				if (adv && pcSel_t'(pcSel) == SEL_MRET)
					mInService = 1'b0;
			end
			mIrqPrev = irq;
			if (mtvecWe)
				mMtvec = mtvecData;
		end
		if (dbgWe)
			memModel[wrIdx] = dbgData; // even in reset
	endtask

	task automatic checkVal(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// runs every falling edge so held outputs under stall get checked too
	task automatic checkOutputs;
		checkBit("valid2", expV2, valid2);
		checkBit("inService", mInService, inService);
		if (expV2)
		begin
			checkVal("pc2", cur.pc, pc2);
			checkVal("instr2", cur.instr, instr2);
			checkBit("misaligned2", cur.mis, misaligned2);
		end
	endtask

	// checks and drives on the falling edge then models the rising edge
	task automatic step(input logic s, input logic [1:0] sel, input word_t tgt);
		@(negedge clk);
		checkOutputs();
		sampledValid2 = valid2;
		sampledInSvc  = inService;
		nrst      = nrstNext;
		stall     = s;
		pcSel     = sel;
		target    = tgt;
		irq       = irqReq;  // one-cycle pulse
		dbgWe     = dbgReq;
		dbgAddr   = dbgReqAddr;
		dbgData   = dbgReqData;
		mtvecWe   = mtvecReq;
		mtvecData = mtvecReqData;
		irqReq    = 1'b0;
		dbgReq    = 1'b0;
		mtvecReq  = 1'b0;
		@(posedge clk);
		modelEdge();
	endtask

	task automatic waitInSvc(input logic level);
		int n;
		n = 0;
		while (sampledInSvc !== level && n < 12)
		begin
			step(1'b0, SEL_SEQ, 32'd0);
			n++;
		end
		if (sampledInSvc !== level)
		begin
			errors++;
			$display("timeout: inService did not reach %b within 12 cycles", level);
		end
	endtask

	// mostly sequential with some branches and a rare reset select
	function automatic logic [1:0] randSel();
		logic [2:0] r;
		r = 3'($urandom % 8);
		if (r == 3'd7)
			return SEL_RESET;
		else if (r >= 3'd5)
			return SEL_TARGET;
		return SEL_SEQ;
	endfunction

	function automatic word_t randTarget();
		return $urandom & 32'h0000_03ff; // whole memory with random low bits
	endfunction

	task automatic finishTest(input string name);
		$display("test %-12s %0d errors", name, errors - testStart);
		testStart = errors;
		tests++;
	endtask

	initial
	begin
		int i;
		int n;
		void'($urandom(32'h9e2f));
		nrst         = 1'b0;
		stall        = 1'b1;
		irq          = 1'b0;
		mtvecWe      = 1'b0;
		dbgWe        = 1'b0;
		pcSel        = SEL_SEQ;
		target       = 32'd0;
		mtvecData    = 32'd0;
		dbgAddr      = 32'd0;
		dbgData      = 32'd0;
		irqReq       = 1'b0;
		dbgReq       = 1'b0;
		mtvecReq     = 1'b0;
		nrstNext     = 1'b0;
		dbgReqAddr   = 32'd0;
		dbgReqData   = 32'd0;
		mtvecReqData = 32'd0;
		resetModel();

		// program load starts in reset and ends with fetch stalled
		for (i = 0; i < 2**`IMEM_WORDS_LOG2; i++)
		begin
			nrstNext   = (i >= 15); // 16 clock periods in reset
			dbgReq     = 1'b1;
			dbgReqAddr = i * 4;
			dbgReqData = $urandom;
			step(1'b1, SEL_SEQ, 32'd0);
		end
		mtvecReq     = 1'b1; // mtvec is held in reset so write it after
		mtvecReqData = 32'h0000_0200;
		step(1'b1, SEL_SEQ, 32'd0);

		repeat (40) step(1'b0, SEL_SEQ, randTarget());
		finishTest("sequential");

		repeat (80) step(1'b0, randSel(), randTarget());
		finishTest("branch");

		repeat (120) step(($urandom % 3) == 0, randSel(), randTarget());
		finishTest("stall");

		irqReq = 1'b1;
		step(1'b0, SEL_SEQ, 32'd0);
		waitInSvc(1'b1);
		repeat (4) step(1'b0, SEL_SEQ, 32'd0);
		irqReq = 1'b1; // must be ignored while in service
		repeat (6) step(1'b0, SEL_SEQ, 32'd0);
		step(1'b0, SEL_MRET, randTarget());
		waitInSvc(1'b0);
		repeat (10) step(1'b0, SEL_SEQ, 32'd0);
		finishTest("interrupt");

		dbgReq     = 1'b1;
		dbgReqAddr = mPc + 32'd16; // four words ahead of stage 1
		dbgReqData = $urandom;
		repeat (10) step(1'b0, SEL_SEQ, 32'd0);
		irqReq = 1'b1;
		step(1'b0, SEL_SEQ, 32'd0);
		waitInSvc(1'b1);
		@(negedge clk);
		#5;
		nrst     = 1'b0; // mid cycle away from any clock edge
		nrstNext = 1'b0;
		resetModel();
		#1;
		checkBit("valid2", 1'b0, valid2);
		checkBit("inService", 1'b0, inService);
		repeat (3) step(1'b0, SEL_SEQ, 32'd0);
		nrstNext = 1'b1;
		n = 0;
		while (!sampledValid2 && n < 12)
		begin
			step(1'b0, SEL_SEQ, 32'd0);
			n++;
		end
		if (!sampledValid2)
		begin
			errors++;
			$display("timeout: valid2 did not return after reset");
		end
		repeat (20) step(1'b0, randSel(), randTarget());
		finishTest("reload/reset");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetchTop.f ====
+incdir+include
src/archPkg.sv
src/memPkg.sv
src/fetchIf.sv
src/pcGen.sv
src/trapUnit.sv
src/instrMem.sv
src/fetchTop.sv
verification/fetchTb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module fetchTb -f fetchTop.f -o fetchSim

run: compile
	@out="$$(./obj_dir/fetchSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
